// File: src/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    // Datapath width and data memory geometry
    localparam int xlen           = 32;
    localparam int dmem_words     = 64;
    localparam int dmem_addr_bits = 6;

    // Distance to the next sequential instruction
    localparam logic [xlen-1:0] pc_step = 32'd4;

    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_and    = 4'd2,
        alu_or     = 4'd3,
        alu_xor    = 4'd4,
        alu_sll    = 4'd5,
        alu_srl    = 4'd6,
        alu_sra    = 4'd7,
        alu_slt    = 4'd8,
        alu_sltu   = 4'd9,
        alu_pass_b = 4'd10
    } alu_op_e;

    // Source of the value written back to rd
    typedef enum logic [1:0] {
        res_alu = 2'd0,
        res_mem = 2'd1,
        res_pc4 = 2'd2
    } res_src_e;

    // Load and store widths, encoded as funct3
    typedef enum logic [2:0] {
        mem_b  = 3'b000,
        mem_h  = 3'b001,
        mem_w  = 3'b010,
        mem_bu = 3'b100,
        mem_hu = 3'b101
    } mem_width_e;

endpackage

`default_nettype wire

// File: src/rv_pipe_pkg.sv
`default_nettype none

package rv_pipe_pkg;

    import rv_isa_pkg::*;

    // Decoded instruction with operand values, as issued to execute
    typedef struct packed {
        logic              valid;
        logic              reg_write;
        logic              mem_write;
        logic              mem_read;
        res_src_e          res_src;
        alu_op_e           alu_op;
        logic              use_imm;
        mem_width_e        width;
        logic [4:0]        rd;
        logic [xlen-1:0]   pc;
        logic [xlen-1:0]   rs1_data;
        logic [xlen-1:0]   rs2_data;
        logic [xlen-1:0]   imm;
    } id_ex_t;

    // Execute results on their way to memory access
    typedef struct packed {
        logic              valid;
        logic              reg_write;
        logic              mem_write;
        res_src_e          res_src;
        mem_width_e        width;
        logic [4:0]        rd;
        logic [xlen-1:0]   alu_result;
        logic [xlen-1:0]   rs2_data;
        logic [xlen-1:0]   pc_plus4;
    } ex_mem_t;

    // Memory stage results; load_data is already extended
    typedef struct packed {
        logic              valid;
        logic              reg_write;
        res_src_e          res_src;
        logic [4:0]        rd;
        logic [xlen-1:0]   alu_result;
        logic [xlen-1:0]   load_data;
        logic [xlen-1:0]   pc_plus4;
    } mem_wb_t;

    // Final register file update leaving the pipeline
    typedef struct packed {
        logic              valid;
        logic              reg_write;
        logic [4:0]        rd;
        logic [xlen-1:0]   data;
    } wb_t;

endpackage

`default_nettype wire

// File: src/rv_alu_stage.sv
`default_nettype none

module rv_alu_stage (
    input  rv_pipe_pkg::id_ex_t  id_ex,
    output rv_pipe_pkg::ex_mem_t ex
);

    import rv_isa_pkg::*;

    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [4:0]      shamt;
    logic [xlen-1:0] result;

    // Second operand is the immediate for I-type and store addressing
    assign op_a  = id_ex.rs1_data;
    assign op_b  = id_ex.use_imm ? id_ex.imm : id_ex.rs2_data;
    assign shamt = op_b[4:0];

    always_comb begin
        case (id_ex.alu_op)
            alu_add:    result = op_a + op_b;
            alu_sub:    result = op_a - op_b;
            alu_and:    result = op_a & op_b;
            alu_or:     result = op_a | op_b;
            alu_xor:    result = op_a ^ op_b;
            alu_sll:    result = op_a << shamt;
            alu_srl:    result = op_a >> shamt;
            alu_sra:    result = $signed(op_a) >>> shamt;
            alu_slt: begin
                result = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            end
            alu_sltu: begin
                result = {{(xlen-1){1'b0}}, op_a < op_b};
            end
            // lui-style, the immediate goes straight through
            alu_pass_b: result = op_b;
            default:    result = '0;
        endcase
    end

    always_comb begin
        ex.valid      = id_ex.valid;
        ex.reg_write  = id_ex.reg_write;
        ex.mem_write  = id_ex.mem_write;
        ex.res_src    = id_ex.res_src;
        ex.width      = id_ex.width;
        ex.rd         = id_ex.rd;
        ex.alu_result = result;
        ex.rs2_data   = id_ex.rs2_data;
        // Return address for jal/jalr style results
        ex.pc_plus4   = id_ex.pc + pc_step;
    end

endmodule

`default_nettype wire

// File: src/rv_reg_ex_mem.sv
`default_nettype none

module rv_reg_ex_mem #(
    parameter int ex_mem_reg = 1
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  rv_pipe_pkg::ex_mem_t ex,
    output rv_pipe_pkg::ex_mem_t mem
);

    import rv_pipe_pkg::*;

    if (ex_mem_reg != 0) begin : g_registered
        logic    valid_q;
        logic    reg_write_q;
        logic    mem_write_q;
        ex_mem_t data_q;

        // Control bits with synchronous reset
        always_ff @(posedge clk) begin
            if (!rst_n) begin
                valid_q     <= 1'b0;
                reg_write_q <= 1'b0;
                mem_write_q <= 1'b0;
            end else begin
                valid_q     <= ex.valid;
                reg_write_q <= ex.reg_write;
                mem_write_q <= ex.mem_write;
            end
        end

        // Payload fields
        always_ff @(posedge clk) begin
            data_q <= ex;
        end

        always_comb begin
            mem           = data_q;
            mem.valid     = valid_q;
            mem.reg_write = reg_write_q;
            mem.mem_write = mem_write_q;
        end
    end else begin : g_passthrough
        // Execute feeds memory access directly when the stage is collapsed
        assign mem = ex;
    end

endmodule

`default_nettype wire

// File: src/rv_mem_stage.sv
`default_nettype none

module rv_mem_stage (
    input  logic                 clk,
    input  rv_pipe_pkg::ex_mem_t mem,
    output rv_pipe_pkg::mem_wb_t mem_wb
);

    import rv_isa_pkg::*;

    logic [xlen-1:0] dmem [dmem_words];

    logic [dmem_addr_bits-1:0] word_addr;
    logic [1:0]                byte_off;
    logic [xlen-1:0]           rd_word;
    logic [xlen-1:0]           wr_word;
    logic [7:0]                sel_byte;
    logic [15:0]               sel_half;
    logic [xlen-1:0]           load_val;

    assign word_addr = mem.alu_result[dmem_addr_bits+1:2];
    assign byte_off  = mem.alu_result[1:0];
    assign rd_word   = dmem[word_addr];

    // Merge store data into the current word
    always_comb begin
        wr_word = rd_word;
        case (mem.width)
            mem_b, mem_bu: wr_word[{byte_off, 3'b000} +: 8] = mem.rs2_data[7:0];
            mem_h, mem_hu: wr_word[{byte_off[1], 4'b0000} +: 16] = mem.rs2_data[15:0];
            default:       wr_word = mem.rs2_data;
        endcase
    end

    // Write lands at the end of the cycle, a following load sees it
    always_ff @(posedge clk) begin
        if (mem.valid && mem.mem_write) begin
            dmem[word_addr] <= wr_word;
        end
    end

    // Load field extraction
    assign sel_byte = rd_word[{byte_off, 3'b000} +: 8];
    assign sel_half = rd_word[{byte_off[1], 4'b0000} +: 16];

    always_comb begin
        case (mem.width)
            mem_b:   load_val = {{(xlen-8){sel_byte[7]}}, sel_byte};
            mem_bu:  load_val = {{(xlen-8){1'b0}}, sel_byte};
            mem_h:   load_val = {{(xlen-16){sel_half[15]}}, sel_half};
            mem_hu:  load_val = {{(xlen-16){1'b0}}, sel_half};
            default: load_val = rd_word;
        endcase
    end

    always_comb begin
        mem_wb.valid      = mem.valid;
        mem_wb.reg_write  = mem.reg_write;
        mem_wb.res_src    = mem.res_src;
        mem_wb.rd         = mem.rd;
        mem_wb.alu_result = mem.alu_result;
        mem_wb.load_data  = load_val;
        mem_wb.pc_plus4   = mem.pc_plus4;
    end

endmodule

`default_nettype wire

// File: src/rv_writeback.sv
`default_nettype none

module rv_writeback (
    input  logic                 clk,
    input  logic                 rst_n,
    input  rv_pipe_pkg::mem_wb_t mem_wb,
    output rv_pipe_pkg::wb_t     wb
);

    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    logic    valid_q;
    logic    reg_write_q;
    mem_wb_t data_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q     <= 1'b0;
            reg_write_q <= 1'b0;
        end else begin
            valid_q     <= mem_wb.valid;
            reg_write_q <= mem_wb.reg_write;
        end
    end

    always_ff @(posedge clk) begin
        data_q <= mem_wb;
    end

    // Pick the final result for rd
    always_comb begin
        wb.valid     = valid_q;
        wb.reg_write = valid_q & reg_write_q;
        wb.rd        = data_q.rd;
        case (data_q.res_src)
            res_mem: wb.data = data_q.load_data;
            res_pc4: wb.data = data_q.pc_plus4;
            default: wb.data = data_q.alu_result;
        endcase
    end

endmodule

`default_nettype wire

// File: src/rv_backend_top.sv
`default_nettype none

module rv_backend_top #(
    parameter int ex_mem_reg = 1
) (
    input  logic                clk,
    input  logic                rst_n,
    input  rv_pipe_pkg::id_ex_t id_ex,
    output rv_pipe_pkg::wb_t    wb
);

    import rv_pipe_pkg::*;

    ex_mem_t ex;
    ex_mem_t mem;
    mem_wb_t mem_wb;

    rv_alu_stage rv_alu_stage_inst (
        .id_ex (id_ex),
        .ex    (ex)
    );

    // Optional register between execute and memory access
    rv_reg_ex_mem #(
        .ex_mem_reg (ex_mem_reg)
    ) rv_reg_ex_mem_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .ex    (ex),
        .mem   (mem)
    );

    rv_mem_stage rv_mem_stage_inst (
        .clk    (clk),
        .mem    (mem),
        .mem_wb (mem_wb)
    );

    rv_writeback rv_writeback_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .mem_wb (mem_wb),
        .wb     (wb)
    );

endmodule

`default_nettype wire

// File: verif/rv_backend_model.svh
`ifndef RV_BACKEND_MODEL_SVH
`define RV_BACKEND_MODEL_SVH
`default_nettype none

// Memory image and write-backs the DUT still owes
logic [xlen-1:0] model_mem [dmem_words];
wb_t             expect_q [$];

function automatic logic [xlen-1:0] alu_ref(alu_op_e op, logic [xlen-1:0] a,
                                            logic [xlen-1:0] b);
    case (op)
        alu_add:  return a + b;
        alu_sub:  return a - b;
        alu_and:  return a & b;
        alu_or:   return a | b;
        alu_xor:  return a ^ b;
        alu_sll:  return a << b[4:0];
        alu_srl:  return a >> b[4:0];
        alu_sra:  return 32'($signed(a) >>> b[4:0]);
        alu_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        alu_sltu: return (a < b) ? 32'd1 : 32'd0;
        default:  return b;
    endcase
endfunction

function automatic logic [xlen-1:0] load_ref(logic [xlen-1:0] word, logic [1:0] off,
                                             mem_width_e width);
    logic [7:0]  bval;
    logic [15:0] hval;
    bval = word[8*off +: 8];
    // Halves are picked by address bit 1 only
    hval = off[1] ? word[31:16] : word[15:0];
    case (width)
        mem_b:   return {{24{bval[7]}}, bval};
        mem_bu:  return {24'd0, bval};
        mem_h:   return {{16{hval[15]}}, hval};
        mem_hu:  return {16'd0, hval};
        default: return word;
    endcase
endfunction

// Executes one valid instruction in issue order
function automatic void model_issue(id_ex_t ins);
    logic [xlen-1:0] res;
    logic [xlen-1:0] word;
    wb_t             w;
    res  = alu_ref(ins.alu_op, ins.rs1_data, ins.use_imm ? ins.imm : ins.rs2_data);
    word = model_mem[res[7:2]];
    w.valid     = 1'b1;
    w.reg_write = ins.reg_write;
    w.rd        = ins.rd;
    case (ins.res_src)
        res_mem: w.data = load_ref(word, res[1:0], ins.width);
        res_pc4: w.data = ins.pc + 32'd4;
        default: w.data = res;
    endcase
    if (ins.mem_write) begin
        case (ins.width)
            mem_b, mem_bu: word[8*res[1:0] +: 8] = ins.rs2_data[7:0];
            mem_h, mem_hu: begin
                if (res[1])
                    word[31:16] = ins.rs2_data[15:0];
                else
                    word[15:0] = ins.rs2_data[15:0];
            end
            default:       word = ins.rs2_data;
        endcase
        model_mem[res[7:2]] = word;
    end
    expect_q.push_back(w);
endfunction

`default_nettype wire
`endif

// File: verif/rv_backend_tb.sv
`default_nettype none

module rv_backend_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    localparam int reset_cycles = 3;
    localparam int n_bubble     = 10;
    localparam int n_alu        = 200;
    localparam int n_sub        = 100;
    localparam int n_mixed      = 150;
    localparam int n_tests      = 5;
    localparam int drain_limit  = 8;
    // Every test slot including worst-case gaps and drains
    localparam int total_slots  = reset_cycles + n_bubble + n_alu + 2 * dmem_words
                                + 2 * n_sub + 2 * n_mixed + n_tests * (drain_limit + 1);
    localparam int cycle_limit  = total_slots + 20;

    logic   clk = 1'b0;
    logic   rst_n;
    id_ex_t id_ex;
    wb_t    wb;

    int         seed = 32'hbc01;
    int         errors = 0;
    int         errors_at_start = 0;
    int         n_pass = 0;
    int         n_fail = 0;
    int         cycles = 0;
    logic [1:0] issued_hist = 2'b00;

    `include "rv_backend_model.svh"

    rv_backend_top rv_backend_top_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .id_ex (id_ex),
        .wb    (wb)
    );

    always #2 clk = ~clk;

    function automatic id_ex_t rand_fields();
        id_ex_t ins;
        ins.valid     = 1'b1;
        ins.reg_write = 1'b1;
        ins.mem_write = 1'b0;
        ins.mem_read  = 1'b0;
        ins.res_src   = res_alu;
        ins.alu_op    = alu_op_e'(4'($unsigned($random(seed)) % 11));
        ins.use_imm   = 1'($random(seed));
        ins.width     = mem_w;
        ins.rd        = 5'($random(seed));
        ins.pc        = 32'($random(seed)) & ~32'd3;
        ins.rs1_data  = $random(seed);
        ins.rs2_data  = $random(seed);
        ins.imm       = $random(seed);
        return ins;
    endfunction

    function automatic id_ex_t bubble();
        id_ex_t ins;
        ins = rand_fields();
        ins.valid = 1'b0;
        ins.mem_write = 1'($random(seed));
        return ins;
    endfunction

    function automatic mem_width_e rand_width(int n);
        case ($unsigned($random(seed)) % n)
            0:       return mem_b;
            1:       return mem_h;
            2:       return mem_bu;
            3:       return mem_hu;
            default: return mem_w;
        endcase
    endfunction

    // Address is split into base plus a small offset
    function automatic id_ex_t mem_insn(logic [31:0] addr, mem_width_e width, logic store);
        id_ex_t ins;
        ins = rand_fields();
        ins.alu_op    = alu_add;
        ins.use_imm   = 1'b1;
        ins.width     = width;
        ins.imm       = 32'($random(seed)) & 32'hff;
        ins.rs1_data  = addr - ins.imm;
        ins.reg_write = ~store;
        ins.mem_write = store;
        ins.mem_read  = ~store;
        ins.res_src   = store ? res_alu : res_mem;
        return ins;
    endfunction

    function automatic id_ex_t rand_insn();
        id_ex_t ins;
        case ($unsigned($random(seed)) % 4)
            0: ins = mem_insn($random(seed), rand_width(5), 1'b0);
            1: ins = mem_insn($random(seed), rand_width(5), 1'b1);
            2: begin
                ins = rand_fields();
                ins.res_src = res_pc4;
            end
            default: ins = rand_fields();
        endcase
        return ins;
    endfunction

    task automatic issue(id_ex_t ins);
        @(posedge clk);
        #1;
        id_ex = ins;
        if (ins.valid)
            model_issue(ins);
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        issue(bubble());
        while (expect_q.size() != 0 && waited < drain_limit) begin
            @(posedge clk);
            waited++;
        end
        assert (expect_q.size() == 0) else begin
            $display("Pipeline never returned %0d expected results", expect_q.size());
            errors++;
        end
    endtask

    task automatic end_test(string name);
        if (errors == errors_at_start) begin
            $display("Test %s: passed", name);
            n_pass++;
        end else begin
            $display("Test %s: failed with %0d errors", name, errors - errors_at_start);
            n_fail++;
        end
        errors_at_start = errors;
    endtask

    task automatic compare(string name, logic [31:0] expected, logic [31:0] actual);
        assert (actual === expected) else begin
            $display("FAIL %s expected %h got %h", name, expected, actual);
            errors++;
        end
    endtask

    // Output checks at the falling edge where wb is settled
    always @(negedge clk) begin : check_wb
        wb_t exp;
        assert (wb.valid === issued_hist[1]) else begin
            if (issued_hist[1])
                $display("Missing write-back two cycles after an issue at %0t", $time);
            else
                $display("Write-back appeared with no matching issue at %0t", $time);
            errors++;
        end
        if (wb.valid === 1'b1) begin
            if (expect_q.size() == 0) begin
                $display("Write-back arrived while no result was expected at %0t", $time);
                errors++;
            end else begin
                exp = expect_q.pop_front();
                compare("wb.rd", 32'(exp.rd), 32'(wb.rd));
                compare("wb.reg_write", 32'(exp.reg_write), 32'(wb.reg_write));
                compare("wb.data", exp.data, wb.data);
            end
        end else begin
            compare("wb.reg_write", 32'd0, 32'(wb.reg_write));
        end
        issued_hist = rst_n ? {issued_hist[0], id_ex.valid} : 2'b00;
    end

    initial begin
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, the tests did not finish", cycles);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        logic [31:0] addr;
        // Valid traffic held during reset must leave no trace on wb
        id_ex = rand_fields();
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst_n = 1'b1;
        id_ex = bubble();

        repeat (n_bubble) issue(bubble());
        drain();
        end_test("reset_and_bubbles");

        repeat (n_alu) issue(rand_fields());
        drain();
        end_test("alu_ops");

        for (int i = 0; i < dmem_words; i++)
            issue(mem_insn(32'(i) << 2, mem_w, 1'b1));
        for (int i = 0; i < dmem_words; i++)
            issue(mem_insn(32'(i) << 2, mem_w, 1'b0));
        drain();
        end_test("word_round_trip");

        // Each load hits the word its store just changed
        repeat (n_sub) begin
            addr = $random(seed);
            issue(mem_insn(addr, rand_width(2), 1'b1));
            issue(mem_insn({addr[31:2], 2'($random(seed))}, rand_width(4), 1'b0));
        end
        drain();
        end_test("sub_word_access");

        repeat (n_mixed) begin
            issue(rand_insn());
            if ($random(seed) & 1)
                issue(bubble());
        end
        drain();
        end_test("mixed_stream");

        $display("Tests passed: %0d, failed: %0d", n_pass, n_fail);
        if (n_fail == 0 && errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+verif
src/rv_isa_pkg.sv
src/rv_pipe_pkg.sv
src/rv_alu_stage.sv
src/rv_reg_ex_mem.sv
src/rv_mem_stage.sv
src/rv_writeback.sv
src/rv_backend_top.sv
verif/rv_backend_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= rv_backend_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= RESULT: PASS
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
